// File: hdl/cbfp_cfg.svh
`ifndef CBFP_CFG_SVH
`define CBFP_CFG_SVH

// sample widths
`define CBFP_IN_W     23    // input real or imag part
`define CBFP_OUT_W    11    // normalized output part

// block exponent holds 0 to 22
`define CBFP_SHIFT_W  5

// block shape
`define CBFP_LANES    16    // samples per beat
`define CBFP_BEATS    4     // beats per block, 64 samples

// fixed right shift after scaling by the block exponent
// in width minus pole gives the output width
`define CBFP_POLE     12

`endif

// File: hdl/cbfp_pkg.sv
`default_nettype none

`include "cbfp_cfg.svh"

package cbfp_pkg;

    // one input sample
    typedef struct packed {
        logic signed [`CBFP_IN_W-1:0] re;
        logic signed [`CBFP_IN_W-1:0] im;
    } cplx_in_t;

    // one normalized sample
    typedef struct packed {
        logic signed [`CBFP_OUT_W-1:0] re;
        logic signed [`CBFP_OUT_W-1:0] im;
    } cplx_out_t;

    typedef cplx_in_t  [`CBFP_LANES-1:0] beat_in_t;   // lane 0 in the low bits
    typedef cplx_out_t [`CBFP_LANES-1:0] beat_out_t;

    // exponent pair, one per part
    typedef struct packed {
        logic [`CBFP_SHIFT_W-1:0] re;
        logic [`CBFP_SHIFT_W-1:0] im;
    } blk_exp_t;

endpackage

`default_nettype wire

// File: hdl/cbfp_exp_detect.sv
`default_nettype none

`include "cbfp_cfg.svh"

module cbfp_exp_detect
    import cbfp_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire logic     din_valid,
    input  wire beat_in_t din,
    output blk_exp_t      blk_exp
);

    localparam int       NODES     = 2 * `CBFP_LANES - 1;
    localparam bit [1:0] LAST_BEAT = 2'(`CBFP_BEATS - 1);

    // redundant sign bits below the msb, 0 to 22
    function automatic logic [`CBFP_SHIFT_W-1:0] sign_run(input logic [`CBFP_IN_W-1:0] x);
        logic [`CBFP_SHIFT_W-1:0] n;
        logic                     stop;
        n    = '0;
        stop = 1'b0;
        for (int b = `CBFP_IN_W - 2; b >= 0; b--) begin
            if (!stop && (x[b] == x[`CBFP_IN_W-1]))
                n = n + 1'b1;
            else
                stop = 1'b1;
        end
        return n;
    endfunction

    function automatic logic [`CBFP_SHIFT_W-1:0] min2(input logic [`CBFP_SHIFT_W-1:0] a,
                                                      input logic [`CBFP_SHIFT_W-1:0] b);
        return (a <= b) ? a : b;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // per-lane counts and min tree
    //////////////////////////////////////////////////////////////////////

    // heap layout: leaves at LANES-1 .. NODES-1, root at 0
    logic [`CBFP_SHIFT_W-1:0] tree_re [NODES];
    logic [`CBFP_SHIFT_W-1:0] tree_im [NODES];
    logic [`CBFP_SHIFT_W-1:0] beat_min_re;
    logic [`CBFP_SHIFT_W-1:0] beat_min_im;

    always_comb begin
        for (int i = 0; i < `CBFP_LANES; i++) begin
            tree_re[`CBFP_LANES-1+i] = sign_run(din[i].re);
            tree_im[`CBFP_LANES-1+i] = sign_run(din[i].im);
        end
        for (int k = `CBFP_LANES - 2; k >= 0; k--) begin
            tree_re[k] = min2(tree_re[2*k+1], tree_re[2*k+2]);
            tree_im[k] = min2(tree_im[2*k+1], tree_im[2*k+2]);
        end
    end

    assign beat_min_re = tree_re[0];
    assign beat_min_im = tree_im[0];

    //////////////////////////////////////////////////////////////////////
    // fold four beats into the block exponent
    //////////////////////////////////////////////////////////////////////

    logic [1:0]               beat_cnt;    // position inside the block
    logic [`CBFP_SHIFT_W-1:0] run_re;      // running minimum so far
    logic [`CBFP_SHIFT_W-1:0] run_im;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_cnt <= '0;
            run_re   <= '0;
            run_im   <= '0;
            blk_exp  <= '0;
        end else if (din_valid) begin
            beat_cnt <= beat_cnt + 1'b1;   // wraps after the last beat
            if (beat_cnt == '0) begin      // first beat restarts the fold
                run_re <= beat_min_re;
                run_im <= beat_min_im;
            end else begin
                run_re <= min2(run_re, beat_min_re);
                run_im <= min2(run_im, beat_min_im);
            end
            if (beat_cnt == LAST_BEAT) begin
                blk_exp.re <= min2(run_re, beat_min_re);
                blk_exp.im <= min2(run_im, beat_min_im);
            end
        end
    end

    // a block, once started, must be fed on consecutive edges
    property p_consecutive_beats;
        @(posedge clk) disable iff (!rstn)
            (beat_cnt != '0) |-> din_valid;
    endproperty

    a_consecutive_beats : assert property (p_consecutive_beats)
        else $error("cbfp_exp_detect: gap inside a block at beat %0d", beat_cnt);

endmodule

`default_nettype wire

// File: hdl/cbfp_block_delay.sv
`default_nettype none

`include "cbfp_cfg.svh"

module cbfp_block_delay
    import cbfp_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire logic     din_valid,
    input  wire beat_in_t din,
    output logic          dly_valid,
    output beat_in_t      dly_beat
);

    //////////////////////////////////////////////////////////////////////
    // one block of delay, valid rides with each beat
    //////////////////////////////////////////////////////////////////////

    beat_in_t               stage_q [`CBFP_BEATS];
    logic [`CBFP_BEATS-1:0] vld_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_q <= '0;
            for (int i = 0; i < `CBFP_BEATS; i++)
                stage_q[i] <= '0;
        end else begin
            vld_q      <= {vld_q[`CBFP_BEATS-2:0], din_valid};
            stage_q[0] <= din;
            for (int i = 1; i < `CBFP_BEATS; i++)
                stage_q[i] <= stage_q[i-1];     // shifts every edge, idle too
        end
    end

    assign dly_valid = vld_q[`CBFP_BEATS-1];
    assign dly_beat  = stage_q[`CBFP_BEATS-1];

    // beat leaves exactly one block length after it came in
    a_valid_delay_hi : assert property (
        @(posedge clk) disable iff (!rstn)
            din_valid |-> ##`CBFP_BEATS dly_valid
    ) else $error("cbfp_block_delay: beat lost in the delay line");

    a_valid_delay_lo : assert property (
        @(posedge clk) disable iff (!rstn)
            !din_valid |-> ##`CBFP_BEATS !dly_valid
    ) else $error("cbfp_block_delay: spurious beat out of the delay line");

endmodule

`default_nettype wire

// File: hdl/cbfp_normalize.sv
`default_nettype none

`include "cbfp_cfg.svh"

module cbfp_normalize
    import cbfp_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire logic     dly_valid,
    input  wire beat_in_t dly_beat,
    input  wire blk_exp_t blk_exp,
    output logic          out_valid,
    output beat_out_t     dout,
    output blk_exp_t      exp_out
);

    localparam int WIDE_W = 2 * `CBFP_IN_W;   // room for the left shift

    // x * 2^e >>> pole, floored
    function automatic logic signed [WIDE_W-1:0] scale(
        input logic signed [`CBFP_IN_W-1:0]    x,
        input logic        [`CBFP_SHIFT_W-1:0] e
    );
        logic signed [WIDE_W-1:0] wide;
        wide = x;                                   // sign extend
        if (e >= `CBFP_POLE)
            return wide <<< (e - `CBFP_POLE);
        else
            return wide >>> (`CBFP_POLE - e);
    endfunction

    // true when v is representable in the output width
    function automatic logic fits_out(input logic signed [WIDE_W-1:0] v);
        return (&v[WIDE_W-1:`CBFP_OUT_W-1]) || !(|v[WIDE_W-1:`CBFP_OUT_W-1]);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // per-lane scaling
    //////////////////////////////////////////////////////////////////////

    wire beat_out_t         nxt_beat;
    wire [`CBFP_LANES-1:0]  lane_ovf;

    for (genvar i = 0; i < `CBFP_LANES; i++) begin : g_lane
        wire logic signed [WIDE_W-1:0] sc_re;
        wire logic signed [WIDE_W-1:0] sc_im;

        assign sc_re = scale(dly_beat[i].re, blk_exp.re);
        assign sc_im = scale(dly_beat[i].im, blk_exp.im);

        assign nxt_beat[i].re = sc_re[`CBFP_OUT_W-1:0];   // upper bits are sign copies
        assign nxt_beat[i].im = sc_im[`CBFP_OUT_W-1:0];
        assign lane_ovf[i]    = !fits_out(sc_re) || !fits_out(sc_im);
    end

    //////////////////////////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
            dout      <= '0;
            exp_out   <= '0;
        end else begin
            out_valid <= dly_valid;
            if (dly_valid) begin
                dout    <= nxt_beat;
                exp_out <= blk_exp;    // exponent of the block this beat belongs to
            end
        end
    end

    // holds only if data and exponent are from the same block
    a_no_overflow : assert property (
        @(posedge clk) disable iff (!rstn)
            dly_valid |-> (lane_ovf == '0)
    ) else $error("cbfp_normalize: scaled value overflows, lanes %h", lane_ovf);

endmodule

`default_nettype wire

// File: hdl/cbfp_stage.sv
`default_nettype none

`include "cbfp_cfg.svh"

module cbfp_stage
    import cbfp_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstn,

    // input beats, four in a row per block
    input  wire logic     din_valid,
    input  wire beat_in_t din,

    // normalized beats, 4 edges after input
    output wire logic      out_valid,
    output wire beat_out_t dout,
    output wire blk_exp_t  exp_out
);

    wire blk_exp_t blk_exp;     // loaded on the last beat of each block
    wire logic     dly_valid;
    wire beat_in_t dly_beat;

    //////////////////////////////////////////////////////////////////////
    // producer, buffer, consumer
    //////////////////////////////////////////////////////////////////////

    cbfp_exp_detect u_exp_detect (
        .clk       (clk),
        .rstn      (rstn),
        .din_valid (din_valid),
        .din       (din),
        .blk_exp   (blk_exp)
    );

    cbfp_block_delay u_block_delay (
        .clk       (clk),
        .rstn      (rstn),
        .din_valid (din_valid),
        .din       (din),
        .dly_valid (dly_valid),
        .dly_beat  (dly_beat)
    );

    cbfp_normalize u_normalize (
        .clk       (clk),
        .rstn      (rstn),
        .dly_valid (dly_valid),
        .dly_beat  (dly_beat),
        .blk_exp   (blk_exp),
        .out_valid (out_valid),
        .dout      (dout),
        .exp_out   (exp_out)
    );

endmodule

`default_nettype wire

// File: test/cbfp_stage_tb.sv
`default_nettype none

`include "cbfp_cfg.svh"

module cbfp_stage_tb
    import cbfp_pkg::*;
();

    localparam int     IN_W     = `CBFP_IN_W;
    localparam int     OUT_W    = `CBFP_OUT_W;
    localparam int     SHIFT_W  = `CBFP_SHIFT_W;
    localparam int     LANES    = `CBFP_LANES;
    localparam int     BEATS    = `CBFP_BEATS;
    localparam int     LAT      = 4;                      // sampling edge to output edge
    localparam longint POLE_DIV = 64'sd1 << `CBFP_POLE;

    // block kinds
    localparam int M_FULL  = 0;
    localparam int M_SMALL = 1;
    localparam int M_SPLIT = 2;
    localparam int M_ZERO  = 3;
    localparam int M_ONES  = 4;

    typedef beat_in_t [BEATS-1:0] block_t;

    // one expected output beat
    typedef struct packed {
        beat_out_t data;
        blk_exp_t  e;
        int        due;        // edge that must register this beat
        int        test_id;
        int        blk_no;
    } expect_t;

    logic      clk;
    logic      rstn;
    logic      din_valid;
    beat_in_t  din;
    logic      out_valid;
    beat_out_t dout;
    blk_exp_t  exp_out;

    integer    seed;
    int        edge_cnt   = 0;
    int        val_errs   = 0;
    int        other_errs = 0;
    int        test_id    = 0;
    int        blk_no     = 0;
    block_t    cur_blk;
    expect_t   exp_q [$];

    cbfp_stage uut (
        .clk       (clk),
        .rstn      (rstn),
        .din_valid (din_valid),
        .din       (din),
        .out_valid (out_valid),
        .dout      (dout),
        .exp_out   (exp_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
        edge_cnt <= edge_cnt + 1;

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // largest e for which x lies in [-2^(22-e), 2^(22-e))
    function automatic int part_exp(input int x);
        int e;
        e = IN_W - 1;
        while (e > 0 && (x < -(1 << (IN_W - 1 - e)) || x >= (1 << (IN_W - 1 - e))))
            e--;
        return e;
    endfunction

    function automatic blk_exp_t ref_block_exp(input block_t b);
        int       min_re;
        int       min_im;
        blk_exp_t r;
        min_re = IN_W - 1;
        min_im = IN_W - 1;
        for (int j = 0; j < BEATS; j++) begin
            for (int i = 0; i < LANES; i++) begin
                if (part_exp(b[j][i].re) < min_re)
                    min_re = part_exp(b[j][i].re);
                if (part_exp(b[j][i].im) < min_im)
                    min_im = part_exp(b[j][i].im);
            end
        end
        r.re = SHIFT_W'(min_re);
        r.im = SHIFT_W'(min_im);
        return r;
    endfunction

    // x * 2^e / 2^pole, rounded toward minus infinity
    function automatic int ref_norm(input int x, input int e);
        longint p;
        longint q;
        p = longint'(x) * (64'sd1 << e);
        q = p / POLE_DIV;
        if (p < 0 && q * POLE_DIV != p)
            q = q - 1;                          // division truncates, floor wants one lower
        return int'(q);
    endfunction

    function automatic string test_label(input int id);
        case (id)
            1:       return "full_scale";
            2:       return "small_magnitude";
            3:       return "split_re_im";
            4:       return "zero_and_minus_one";
            5:       return "back_to_back";
            6:       return "idle_gaps";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_val(input string name, input logic signed [31:0] expv,
                             input logic signed [31:0] actv);
        if (expv !== actv) begin
            $display("** Error: %s expected %0d actual %0d", name, expv, actv);
            val_errs++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic make_block(input int mode);
        int big_lane;
        big_lane = $unsigned($random(seed)) % LANES;
        for (int j = 0; j < BEATS; j++) begin
            for (int i = 0; i < LANES; i++) begin
                case (mode)
                    M_FULL: begin
                        cur_blk[j][i].re = IN_W'($random(seed));
                        cur_blk[j][i].im = IN_W'($random(seed));
                    end
                    M_SMALL: begin                             // within +-2^8
                        cur_blk[j][i].re = IN_W'($random(seed) % 257);
                        cur_blk[j][i].im = IN_W'($random(seed) % 257);
                    end
                    M_SPLIT: begin
                        cur_blk[j][i].re = IN_W'($random(seed) % 17);
                        if (j == 2 && i == big_lane)           // one large imag part
                            cur_blk[j][i].im = IN_W'(32'h0010_0000 |
                                                     ($random(seed) & 32'h000f_ffff));
                        else
                            cur_blk[j][i].im = IN_W'($random(seed) % 17);
                    end
                    M_ONES: begin
                        cur_blk[j][i].re = '1;
                        cur_blk[j][i].im = '1;
                    end
                    default: begin
                        cur_blk[j][i].re = '0;
                        cur_blk[j][i].im = '0;
                    end
                endcase
            end
        end
    endtask

    task automatic go_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            din_valid = 1'b0;
            din       = '0;
        end
    endtask

    // idle for gap cycles, then drive cur_blk on consecutive edges
    task automatic send_block(input int gap);
        blk_exp_t e;
        expect_t  ent;
        go_idle(gap);
        e = ref_block_exp(cur_blk);
        blk_no++;
        for (int j = 0; j < BEATS; j++) begin
            @(negedge clk);
            for (int i = 0; i < LANES; i++) begin
                ent.data[i].re = OUT_W'(ref_norm(cur_blk[j][i].re, e.re));
                ent.data[i].im = OUT_W'(ref_norm(cur_blk[j][i].im, e.im));
            end
            ent.e       = e;
            ent.due     = edge_cnt + 1 + LAT;    // sampled at the next rising edge
            ent.test_id = test_id;
            ent.blk_no  = blk_no;
            exp_q.push_back(ent);
            din_valid = 1'b1;
            din       = cur_blk[j];
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // scoreboard, sampled on the falling edge
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin : compare
        expect_t ent;
        string   tag;
        if (!rstn) begin
            if (out_valid !== 1'b0) begin
                $display("out_valid is not low during reset, edge %0d", edge_cnt);
                other_errs++;
            end
        end else if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("output beat at edge %0d while no beat was expected", edge_cnt);
                other_errs++;
            end else begin
                ent = exp_q.pop_front();
                tag = $sformatf("%s blk %0d", test_label(ent.test_id), ent.blk_no);
                if (ent.due != edge_cnt) begin
                    $display("%s: beat came out at edge %0d instead of edge %0d",
                             tag, edge_cnt, ent.due);
                    other_errs++;
                end
                check_val({tag, " exp re"}, ent.e.re, exp_out.re);
                check_val({tag, " exp im"}, ent.e.im, exp_out.im);
                for (int i = 0; i < LANES; i++) begin
                    check_val($sformatf("%s lane %0d re", tag, i), ent.data[i].re, dout[i].re);
                    check_val($sformatf("%s lane %0d im", tag, i), ent.data[i].im, dout[i].im);
                end
            end
        end else if (exp_q.size() != 0 && exp_q[0].due <= edge_cnt) begin
            $display("%s blk %0d: expected beat missing at edge %0d",
                     test_label(exp_q[0].test_id), exp_q[0].blk_no, edge_cnt);
            other_errs++;
            void'(exp_q.pop_front());
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : main
        int gap;
        int wait_cnt;
        seed      = 17857;
        rstn      = 1'b0;
        din_valid = 1'b0;
        din       = '0;
        cur_blk   = '0;
        repeat (16) @(negedge clk);
        rstn = 1'b1;
        go_idle(3);

        test_id = 1;
        for (int k = 0; k < 4; k++) begin
            make_block(M_FULL);
            send_block(2);
        end
        go_idle(4);

        test_id = 2;
        for (int k = 0; k < 3; k++) begin
            make_block(M_SMALL);
            send_block(2);
        end
        go_idle(4);

        test_id = 3;
        for (int k = 0; k < 3; k++) begin
            make_block(M_SPLIT);
            send_block(2);
        end
        go_idle(4);

        test_id = 4;
        make_block(M_ZERO);
        send_block(1);
        make_block(M_ONES);
        send_block(1);
        go_idle(4);

        test_id = 5;                                   // exponents change every block
        for (int k = 0; k < 6; k++) begin
            make_block(k % 5);
            send_block(0);
        end
        go_idle(4);

        test_id = 6;
        for (int k = 0; k < 8; k++) begin
            gap = 1 + $unsigned($random(seed)) % 9;
            make_block($unsigned($random(seed)) % 5);
            send_block(gap);
        end
        go_idle(1);

        // drain the pipeline
        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < 100) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d expected beats never came out", exp_q.size());
            other_errs++;
        end
        go_idle(8);
        if (exp_q.size() != 0) begin
            $display("scoreboard queue is not empty at the end");
            other_errs++;
        end

        $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
        if (val_errs + other_errs == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: cbfp_stage.f
+incdir+hdl
hdl/cbfp_pkg.sv
hdl/cbfp_exp_detect.sv
hdl/cbfp_block_delay.sv
hdl/cbfp_normalize.sv
hdl/cbfp_stage.sv
test/cbfp_stage_tb.sv

// File: Bender.yml
package:
  name: cbfp_stage

export_include_dirs:
  - hdl

sources:
  # design, in compile order
  - include_dirs:
      - hdl
    files:
      - hdl/cbfp_pkg.sv
      - hdl/cbfp_exp_detect.sv
      - hdl/cbfp_block_delay.sv
      - hdl/cbfp_normalize.sv
      - hdl/cbfp_stage.sv

  # testbench
  - target: test
    include_dirs:
      - hdl
    files:
      - test/cbfp_stage_tb.sv
